// File: dma_pkg.sv
`default_nettype none

package dma_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and field widths
	////////////////////////////////////////////////////////////////////////////

	// word address width on the master bus
	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	// picks one of 32 device interrupt lines
	localparam int DEV_W = 5;
	// largest buffer depth, log2; sizes the block length and nread fields
	localparam int MAX_LGMEMLEN = 10;

	// key in control bits 27..16 that starts a transfer
	localparam logic [11:0] START_KEY = 12'hfed;
	// whole control word that aborts a busy transfer
	localparam logic [DATA_W-1:0] ABORT_WORD = 32'hffed0000;

	// slave register map, one word each
	typedef enum logic [1:0] {
		REG_CTRL,
		REG_LEN,
		REG_SRC,
		REG_DST
	} dma_reg_e;

	// transfer FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_READ_REQ,
		ST_READ_ACK,
		ST_PRE_WRITE,
		ST_WRITE_REQ,
		ST_WRITE_ACK
	} dma_state_e;

	////////////////////////////////////////////////////////////////////////////
	// wishbone ports
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		dma_reg_e addr;
		logic [DATA_W-1:0] data;
	} wb_slave_req_t;

	typedef struct packed {
		logic ack;
		logic stall;
		logic [DATA_W-1:0] data;
	} wb_slave_rsp_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} wb_master_req_t;

	typedef struct packed {
		logic stall;
		logic ack;
		logic err;
		logic [DATA_W-1:0] data;
	} wb_master_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// buses between the register block, the engine and the buffer
	////////////////////////////////////////////////////////////////////////////

	// settings held in the control register
	typedef struct packed {
		logic incs;
		logic incd;
		logic on_dev_trigger;
		logic [DEV_W-1:0] dev_sel;
		logic [MAX_LGMEMLEN-1:0] blocklen_sub_one;
	} dma_ctrl_t;

	// single-cycle commands decoded from slave writes
	typedef struct packed {
		logic ld_len;
		logic ld_src;
		logic ld_dst;
		logic start;
		logic abort;
		logic clr_err;
		logic [DATA_W-1:0] wdata;
	} dma_cmd_t;

	// live engine state for readback
	typedef struct packed {
		logic busy;
		logic err;
		logic [MAX_LGMEMLEN:0] nread;
		logic [ADDR_W-1:0] len;
		logic [ADDR_W-1:0] raddr;
		logic [ADDR_W-1:0] waddr;
	} dma_status_t;

	// buffer fill port, one word per read ack
	typedef struct packed {
		logic we;
		logic [MAX_LGMEMLEN-1:0] idx;
		logic [DATA_W-1:0] data;
	} dma_buf_wr_t;

endpackage

`default_nettype wire

// File: dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regs #(
	parameter int LGMEMLEN = 10
) (
	input wire i_clk,
	input wire i_reset,
	input wire dma_pkg::wb_slave_req_t i_swb,
	output dma_pkg::wb_slave_rsp_t o_swb,
	input wire dma_pkg::dma_status_t i_status,
	output dma_pkg::dma_ctrl_t o_ctrl,
	output dma_pkg::dma_cmd_t o_cmd
);

	localparam logic [LGMEMLEN-1:0] BLK_ONE = 1;

	// write decode
	logic wr_req;
	logic wr_idle;
	logic ctrl_wr;
	logic start_ok;

	// control register fields
	logic r_incs;
	logic r_incd;
	logic r_on_dev;
	logic [dma_pkg::DEV_W-1:0] r_dev_sel;
	logic [LGMEMLEN-1:0] r_blocklen;

	// slave response
	logic r_ack;
	logic [dma_pkg::DATA_W-1:0] r_rdata;
	logic [dma_pkg::DATA_W-1:0] ctrl_word;

	////////////////////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////////////////////

	assign wr_req = i_swb.cyc && i_swb.stb && i_swb.we;
	// config writes only count while the engine is idle
	assign wr_idle = wr_req && !i_status.busy;
	assign ctrl_wr = wr_req && (i_swb.addr == dma_pkg::REG_CTRL);

	// start needs the key, zero top bits and something left to move
	assign start_ok = (i_swb.data[27:16] == dma_pkg::START_KEY)
		&& (i_swb.data[31:30] == 2'b00)
		&& (i_status.len != '0);

	always_comb
	begin
		o_cmd = '0;
		o_cmd.wdata = i_swb.data;
		o_cmd.ld_len = wr_idle && (i_swb.addr == dma_pkg::REG_LEN);
		o_cmd.ld_src = wr_idle && (i_swb.addr == dma_pkg::REG_SRC);
		o_cmd.ld_dst = wr_idle && (i_swb.addr == dma_pkg::REG_DST);
		// any idle control write clears a stale error
		o_cmd.clr_err = ctrl_wr && !i_status.busy;
		o_cmd.start = ctrl_wr && !i_status.busy && start_ok;
		// abort is the only control write honoured while busy
		o_cmd.abort = ctrl_wr && i_status.busy
			&& (i_swb.data == dma_pkg::ABORT_WORD);
	end

	////////////////////////////////////////////////////////////////////////////
	// control register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_incs <= 1'b0;
			r_incd <= 1'b0;
			r_on_dev <= 1'b0;
			r_dev_sel <= '0;
			// full buffer per block
			r_blocklen <= '1;
		end
		else if (ctrl_wr && !i_status.busy)
		begin
			// bits 29/28 are increment-disable flags
			r_incs <= !i_swb.data[29];
			r_incd <= !i_swb.data[28];
			r_on_dev <= i_swb.data[15];
			r_dev_sel <= i_swb.data[14:10];
			// a written zero wraps to all ones, the full buffer
			r_blocklen <= i_swb.data[LGMEMLEN-1:0] - BLK_ONE;
		end

	always_comb
	begin
		o_ctrl = '0;
		o_ctrl.incs = r_incs;
		o_ctrl.incd = r_incd;
		o_ctrl.on_dev_trigger = r_on_dev;
		o_ctrl.dev_sel = r_dev_sel;
		o_ctrl.blocklen_sub_one[LGMEMLEN-1:0] = r_blocklen;
	end

	////////////////////////////////////////////////////////////////////////////
	// readback and ack
	////////////////////////////////////////////////////////////////////////////

	// busy, err, flags, progress, trigger setup, block length
	assign ctrl_word = {i_status.busy, i_status.err, !r_incs, !r_incd, 1'b0,
		i_status.nread, r_on_dev, r_dev_sel, o_ctrl.blocklen_sub_one};

	// registered mux, presented with the ack
	always_ff @(posedge i_clk)
		case (i_swb.addr)
		dma_pkg::REG_CTRL:
			r_rdata <= ctrl_word;
		dma_pkg::REG_LEN:
			r_rdata <= {{(dma_pkg::DATA_W-dma_pkg::ADDR_W){1'b0}}, i_status.len};
		dma_pkg::REG_SRC:
			r_rdata <= {i_status.raddr, 2'b00};
		default:
			r_rdata <= {i_status.waddr, 2'b00};
		endcase

	// every strobe acked one cycle later, never stalled
	always_ff @(posedge i_clk)
		if (i_reset)
			r_ack <= 1'b0;
		else
			r_ack <= i_swb.cyc && i_swb.stb;

	always_comb
	begin
		o_swb.ack = r_ack;
		o_swb.stall = 1'b0;
		o_swb.data = r_rdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// no ack without a strobe on the cycle before
	a_ack_follows_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		o_swb.ack |-> $past(i_swb.cyc && i_swb.stb));

	// start and abort come from opposite busy states
	a_start_abort_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_cmd.start && o_cmd.abort));

endmodule

`default_nettype wire

// File: dma_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_buffer #(
	parameter int LGMEMLEN = 10
) (
	input wire i_clk,
	input wire i_reset,
	input wire dma_pkg::dma_buf_wr_t i_wr,
	input wire i_rd_restart,
	input wire i_rd_advance,
	output logic [dma_pkg::DATA_W-1:0] o_rd_data
);

	localparam int DEPTH = 1 << LGMEMLEN;
	localparam logic [LGMEMLEN-1:0] PTR_ONE = 1;

	// one block of words
	logic [dma_pkg::DATA_W-1:0] mem [0:DEPTH-1];
	// always one word ahead of the bus during the write phase
	logic [LGMEMLEN-1:0] rdaddr;

	// fill side, indexed by the read ack count
	always_ff @(posedge i_clk)
		if (i_wr.we)
			mem[i_wr.idx[LGMEMLEN-1:0]] <= i_wr.data;

	// read pointer
	// restart parks it at word zero between blocks
	always_ff @(posedge i_clk)
		if (i_reset || i_rd_restart)
			rdaddr <= '0;
		else if (i_rd_advance)
			rdaddr <= rdaddr + PTR_ONE;

	// registered output word, held while the bus stalls
	always_ff @(posedge i_clk)
		if (i_rd_advance)
			o_rd_data <= mem[rdaddr];

endmodule

`default_nettype wire

// File: dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine #(
	parameter int LGMEMLEN = 10
) (
	input wire i_clk,
	input wire i_reset,
	input wire dma_pkg::dma_ctrl_t i_ctrl,
	input wire dma_pkg::dma_cmd_t i_cmd,
	output dma_pkg::dma_status_t o_status,
	input wire [(1 << dma_pkg::DEV_W)-1:0] i_dev_ints,
	output dma_pkg::wb_master_req_t o_mwb,
	input wire dma_pkg::wb_master_rsp_t i_mwb,
	output dma_pkg::dma_buf_wr_t o_buf_wr,
	output logic o_rd_restart,
	output logic o_rd_advance,
	input wire [dma_pkg::DATA_W-1:0] i_rd_data,
	output logic o_interrupt
);

	// counters carry one extra bit so a full block fits
	localparam int CW = LGMEMLEN + 1;
	localparam int AW = dma_pkg::ADDR_W;
	localparam logic [CW-1:0] C_ONE = 1;
	localparam logic [CW-1:0] C_TWO = 2;
	localparam logic [AW-1:0] A_ONE = 1;

	dma_pkg::dma_state_e state;

	// working registers
	logic [AW-1:0] len;
	logic [AW-1:0] raddr;
	logic [AW-1:0] waddr;
	logic [AW-1:0] req_addr;

	// per-block counters
	logic [CW-1:0] nracks;
	logic [CW-1:0] nread;
	logic [CW-1:0] nwritten;
	logic [CW-1:0] nwacks;
	logic [CW-1:0] full_words;
	logic [CW-1:0] blk_words;

	logic last_read_request;
	logic last_read_ack;
	logic last_write_request;
	logic last_write_ack;
	logic trigger;
	logic err_flag;

	// bus events
	logic rd_phase;
	logic wr_phase;
	logic rd_accept;
	logic wr_accept;
	logic rd_ack;
	logic wr_ack;
	logic bus_err;
	logic final_ack;

	////////////////////////////////////////////////////////////////////////////
	// bus events and block size
	////////////////////////////////////////////////////////////////////////////

	assign rd_phase = (state == dma_pkg::ST_READ_REQ) || (state == dma_pkg::ST_READ_ACK);
	assign wr_phase = (state == dma_pkg::ST_WRITE_REQ) || (state == dma_pkg::ST_WRITE_ACK);
	assign rd_accept = (state == dma_pkg::ST_READ_REQ) && !i_mwb.stall;
	assign wr_accept = (state == dma_pkg::ST_WRITE_REQ) && !i_mwb.stall;
	assign rd_ack = rd_phase && i_mwb.ack;
	assign wr_ack = wr_phase && i_mwb.ack;
	assign bus_err = o_mwb.cyc && i_mwb.err;
	// last write ack of the whole transfer
	assign final_ack = wr_ack && last_write_ack && (len == A_ONE);

	// block is the buffer setting, or whatever is left if smaller
	// len is steady through the read phase
	assign full_words = {1'b0, i_ctrl.blocklen_sub_one[LGMEMLEN-1:0]} + C_ONE;
	assign blk_words = (len >= {{(AW-CW){1'b0}}, full_words}) ? full_words : len[CW-1:0];

	////////////////////////////////////////////////////////////////////////////
	// transfer FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
		if (i_reset)
			state <= dma_pkg::ST_IDLE;
		else
			case (state)
			dma_pkg::ST_IDLE:
				if (i_cmd.start)
					state <= dma_pkg::ST_WAIT;
			dma_pkg::ST_WAIT:
				if (i_cmd.abort)
					state <= dma_pkg::ST_IDLE;
				else if (trigger)
					state <= dma_pkg::ST_READ_REQ;
			dma_pkg::ST_READ_REQ, dma_pkg::ST_READ_ACK:
				if (bus_err || i_cmd.abort)
					state <= dma_pkg::ST_IDLE;
				else if (rd_ack && last_read_ack)
					state <= dma_pkg::ST_PRE_WRITE;
				else if (rd_accept && last_read_request)
					state <= dma_pkg::ST_READ_ACK;
			// one cycle to prime the buffer output word
			dma_pkg::ST_PRE_WRITE:
				state <= i_cmd.abort ? dma_pkg::ST_IDLE : dma_pkg::ST_WRITE_REQ;
			dma_pkg::ST_WRITE_REQ, dma_pkg::ST_WRITE_ACK:
				if (bus_err || i_cmd.abort)
					state <= dma_pkg::ST_IDLE;
				else if (wr_ack && last_write_ack)
					// back through wait for the next block
					state <= (len == A_ONE) ? dma_pkg::ST_IDLE : dma_pkg::ST_WAIT;
				else if (wr_accept && last_write_request)
					state <= dma_pkg::ST_WRITE_ACK;
			default:
				state <= dma_pkg::ST_IDLE;
			endcase

	// trigger
	// registered, so a block starts two cycles into wait at the earliest
	always_ff @(posedge i_clk)
		if (i_reset)
			trigger <= 1'b0;
		else
			trigger <= (state == dma_pkg::ST_WAIT)
				&& (!i_ctrl.on_dev_trigger || i_dev_ints[i_ctrl.dev_sel]);

	////////////////////////////////////////////////////////////////////////////
	// working length and addresses
	////////////////////////////////////////////////////////////////////////////

	// remaining words, down one per write ack
	always_ff @(posedge i_clk)
		if (i_reset)
			len <= '0;
		else if (i_cmd.ld_len)
			len <= i_cmd.wdata[AW-1:0];
		else if (wr_ack)
			len <= len - A_ONE;

	// byte address written, word address kept
	always_ff @(posedge i_clk)
		if (i_reset)
			raddr <= '0;
		else if (i_cmd.ld_src)
			raddr <= i_cmd.wdata[AW+1:2];
		else if (rd_ack && i_ctrl.incs)
			raddr <= raddr + A_ONE;

	always_ff @(posedge i_clk)
		if (i_reset)
			waddr <= '0;
		else if (i_cmd.ld_dst)
			waddr <= i_cmd.wdata[AW+1:2];
		else if (wr_ack && i_ctrl.incd)
			waddr <= waddr + A_ONE;

	// request address runs ahead of the acked address
	// only moves on acceptance, so it holds under stall
	always_ff @(posedge i_clk)
		if ((state == dma_pkg::ST_IDLE) || (state == dma_pkg::ST_WAIT))
			req_addr <= raddr;
		else if (state == dma_pkg::ST_PRE_WRITE)
			req_addr <= waddr;
		else if ((rd_accept && i_ctrl.incs) || (wr_accept && i_ctrl.incd))
			req_addr <= req_addr + A_ONE;

	////////////////////////////////////////////////////////////////////////////
	// counters and last flags
	////////////////////////////////////////////////////////////////////////////

	// read side, cleared between blocks
	// nread stays valid through the write phase as the word count
	always_ff @(posedge i_clk)
		if (i_reset || (state == dma_pkg::ST_IDLE) || (state == dma_pkg::ST_WAIT))
		begin
			nracks <= '0;
			nread <= '0;
		end
		else
		begin
			if (rd_accept)
				nracks <= nracks + C_ONE;
			if (rd_ack)
				nread <= nread + C_ONE;
		end

	// write side
	always_ff @(posedge i_clk)
		if (i_reset || !wr_phase)
		begin
			nwritten <= '0;
			nwacks <= '0;
		end
		else
		begin
			if (wr_accept)
				nwritten <= nwritten + C_ONE;
			if (wr_ack)
				nwacks <= nwacks + C_ONE;
		end

	// request flags mark the word on the bus as the last
	// ack flags mark the next ack as the last
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			last_read_request <= 1'b0;
			last_read_ack <= 1'b0;
			last_write_request <= 1'b0;
			last_write_ack <= 1'b0;
		end
		else
			case (state)
			dma_pkg::ST_WAIT:
			begin
				last_read_request <= (blk_words == C_ONE);
				last_read_ack <= (blk_words == C_ONE);
			end
			dma_pkg::ST_READ_REQ, dma_pkg::ST_READ_ACK:
			begin
				if (rd_accept)
					last_read_request <= (nracks + C_TWO == blk_words);
				if (rd_ack)
					last_read_ack <= (nread + C_TWO == blk_words);
			end
			dma_pkg::ST_PRE_WRITE:
			begin
				last_write_request <= (nread == C_ONE);
				last_write_ack <= (nread == C_ONE);
			end
			dma_pkg::ST_WRITE_REQ, dma_pkg::ST_WRITE_ACK:
			begin
				if (wr_accept)
					last_write_request <= (nwritten + C_TWO == nread);
				if (wr_ack)
					last_write_ack <= (nwacks + C_TWO == nread);
			end
			default:
			begin
				last_read_request <= 1'b0;
				last_read_ack <= 1'b0;
				last_write_request <= 1'b0;
				last_write_ack <= 1'b0;
			end
			endcase

	////////////////////////////////////////////////////////////////////////////
	// error and interrupt
	////////////////////////////////////////////////////////////////////////////

	// sticky until the next idle control write
	always_ff @(posedge i_clk)
		if (i_reset || i_cmd.clr_err)
			err_flag <= 1'b0;
		else if (bus_err || i_cmd.abort)
			err_flag <= 1'b1;

	// one-cycle pulse after the final write ack or a bus error
	always_ff @(posedge i_clk)
		if (i_reset)
			o_interrupt <= 1'b0;
		else
			o_interrupt <= final_ack || bus_err;

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_mwb.cyc = rd_phase || wr_phase;
		o_mwb.stb = (state == dma_pkg::ST_READ_REQ) || (state == dma_pkg::ST_WRITE_REQ);
		o_mwb.we = (state == dma_pkg::ST_PRE_WRITE) || wr_phase;
		o_mwb.addr = req_addr;
		// buffer output word, only meaningful while writing
		o_mwb.data = i_rd_data;
	end

	// read data lands at the ack count
	always_comb
	begin
		o_buf_wr = '0;
		o_buf_wr.we = rd_ack;
		o_buf_wr.idx[LGMEMLEN-1:0] = nread[LGMEMLEN-1:0];
		o_buf_wr.data = i_mwb.data;
	end

	// read pointer parked outside the write phase
	// pre-write loads word zero, each accepted write loads the next
	assign o_rd_restart = !((state == dma_pkg::ST_PRE_WRITE) || wr_phase);
	assign o_rd_advance = (state == dma_pkg::ST_PRE_WRITE) || wr_accept;

	always_comb
	begin
		o_status = '0;
		o_status.busy = (state != dma_pkg::ST_IDLE);
		o_status.err = err_flag;
		o_status.nread[CW-1:0] = nread;
		o_status.len = len;
		o_status.raddr = raddr;
		o_status.waddr = waddr;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mwb.stb |-> o_mwb.cyc);

	// a stalled request stays put unless the transfer is being torn down
	a_stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_mwb.stb && i_mwb.stall && !i_mwb.err && !i_cmd.abort)
		|=> (o_mwb.stb && $stable(o_mwb.addr) && $stable(o_mwb.we)));

endmodule

`default_nettype wire

// File: dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top #(
	parameter int LGMEMLEN = 10
) (
	input wire i_clk,
	input wire i_reset,
	// control port
	input wire dma_pkg::wb_slave_req_t i_swb,
	output dma_pkg::wb_slave_rsp_t o_swb,
	// copy port
	output dma_pkg::wb_master_req_t o_mwb,
	input wire dma_pkg::wb_master_rsp_t i_mwb,
	input wire [(1 << dma_pkg::DEV_W)-1:0] i_dev_ints,
	output logic o_interrupt
);

	// register block to engine
	dma_pkg::dma_ctrl_t ctrl;
	dma_pkg::dma_cmd_t cmd;
	dma_pkg::dma_status_t status;

	// engine to buffer
	dma_pkg::dma_buf_wr_t buf_wr;
	logic rd_restart;
	logic rd_advance;
	logic [dma_pkg::DATA_W-1:0] rd_data;

	////////////////////////////////////////////////////////////////////////////
	// slave registers
	////////////////////////////////////////////////////////////////////////////

	dma_regs #(
		.LGMEMLEN(LGMEMLEN)
	) u_regs (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_swb(i_swb),
		.o_swb(o_swb),
		.i_status(status),
		.o_ctrl(ctrl),
		.o_cmd(cmd)
	);

	////////////////////////////////////////////////////////////////////////////
	// transfer engine and block buffer
	////////////////////////////////////////////////////////////////////////////

	dma_engine #(
		.LGMEMLEN(LGMEMLEN)
	) u_engine (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ctrl(ctrl),
		.i_cmd(cmd),
		.o_status(status),
		.i_dev_ints(i_dev_ints),
		.o_mwb(o_mwb),
		.i_mwb(i_mwb),
		.o_buf_wr(buf_wr),
		.o_rd_restart(rd_restart),
		.o_rd_advance(rd_advance),
		.i_rd_data(rd_data),
		.o_interrupt(o_interrupt)
	);

	// one block, filled by reads and drained by writes
	dma_buffer #(
		.LGMEMLEN(LGMEMLEN)
	) u_buffer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_wr(buf_wr),
		.i_rd_restart(rd_restart),
		.i_rd_advance(rd_advance),
		.o_rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: tb_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma;

	// small buffer so copies span several blocks
	localparam int LGMEMLEN = 4;
	localparam int MEM_W = 10;
	localparam int TMO = 4000;
	// start key sitting in control bits 27..16
	localparam logic [31:0] GO = 32'h0fed0000;

	logic i_clk = 1'b0;
	logic i_reset = 1'b1;
	dma_pkg::wb_slave_req_t i_swb = '0;
	dma_pkg::wb_slave_rsp_t o_swb;
	dma_pkg::wb_master_req_t o_mwb;
	dma_pkg::wb_master_rsp_t i_mwb = '0;
	logic [31:0] i_dev_ints = '0;
	logic o_interrupt;

	// memory behind the master port, word addressed
	logic [31:0] mem [0:(1 << MEM_W)-1];
	logic err_armed = 1'b0;
	logic [MEM_W-1:0] err_word = '0;

	int irq_count = 0;
	int test_errors = 0;
	int passed = 0;
	int failed = 0;

	dma_top #(
		.LGMEMLEN(LGMEMLEN)
	) DUT (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_swb(i_swb),
		.o_swb(o_swb),
		.o_mwb(o_mwb),
		.i_mwb(i_mwb),
		.i_dev_ints(i_dev_ints),
		.o_interrupt(o_interrupt)
	);

	always #10 i_clk = ~i_clk;

	// every bit of the word address shows up in the pattern
	function automatic logic [31:0] fill_word(input logic [MEM_W-1:0] a);
		return {6'h2b, a, 6'h15, ~a};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// wishbone memory model
	////////////////////////////////////////////////////////////////////////////

	// random stall, ack one cycle after acceptance, err on the armed word
	initial
	begin
		int i;
		void'($urandom(48105));
		for (i = 0; i < (1 << MEM_W); i++)
			mem[i] = fill_word(MEM_W'(i));
		forever
		begin
			@(posedge i_clk);
			if (i_reset)
				i_mwb <= '0;
			else
			begin
				i_mwb.ack <= 1'b0;
				i_mwb.err <= 1'b0;
				i_mwb.stall <= ($urandom_range(3) == 0);
				if (o_mwb.cyc && o_mwb.stb && !i_mwb.stall)
				begin
					if (err_armed && (o_mwb.addr[MEM_W-1:0] == err_word))
						i_mwb.err <= 1'b1;
					else
					begin
						i_mwb.ack <= 1'b1;
						if (o_mwb.we)
							mem[o_mwb.addr[MEM_W-1:0]] <= o_mwb.data;
						else
							i_mwb.data <= mem[o_mwb.addr[MEM_W-1:0]];
					end
				end
			end
		end
	end

	// interrupt pulses seen
	always @(negedge i_clk)
		if (o_interrupt)
			irq_count = irq_count + 1;

	// hard stop in case a loop bound is ever missed
	initial
	begin
		#5000000;
		$display("simulation ran past its time limit");
		$display(">>> FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		test_errors++;
	endtask

	// one strobe, then wait for the ack at a falling edge
	task automatic slave_access(input logic we, input dma_pkg::dma_reg_e a,
		input logic [31:0] d, output logic [31:0] q);
		dma_pkg::wb_slave_req_t req;
		int n;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.addr = a;
		req.data = d;
		@(posedge i_clk);
		i_swb <= req;
		@(negedge i_clk);
		// the slave port never holds off a strobe
		if (o_swb.stall !== 1'b0)
			report_mismatch("slave stall", {31'b0, o_swb.stall}, 32'd0);
		@(posedge i_clk);
		i_swb <= '0;
		@(negedge i_clk);
		n = 0;
		while (!o_swb.ack && (n < 20))
		begin
			@(negedge i_clk);
			n++;
		end
		if (!o_swb.ack)
		begin
			$display("slave port never acked an access at %0t ns", $time);
			test_errors++;
		end
		else if (n != 0)
			report_mismatch("slave ack delay in cycles", n + 1, 32'd1);
		q = o_swb.data;
	endtask

	task automatic slave_write(input dma_pkg::dma_reg_e a, input logic [31:0] d);
		logic [31:0] unused;
		slave_access(1'b1, a, d, unused);
	endtask

	task automatic slave_read(input dma_pkg::dma_reg_e a, output logic [31:0] q);
		slave_access(1'b0, a, 32'h0, q);
	endtask

	// source and destination go in as byte addresses
	task automatic start_copy(input logic [MEM_W-1:0] src, input logic [MEM_W-1:0] dst,
		input logic [29:0] len, input logic [31:0] flags);
		slave_write(dma_pkg::REG_LEN, {2'b00, len});
		slave_write(dma_pkg::REG_SRC, {20'h0, src, 2'b00});
		slave_write(dma_pkg::REG_DST, {20'h0, dst, 2'b00});
		slave_write(dma_pkg::REG_CTRL, GO | flags);
	endtask

	task automatic wait_interrupt();
		int n;
		n = 0;
		@(negedge i_clk);
		while (!o_interrupt && (n < TMO))
		begin
			@(negedge i_clk);
			n++;
		end
		if (!o_interrupt)
		begin
			$display("no interrupt within %0d cycles at %0t ns", TMO, $time);
			test_errors++;
		end
	endtask

	// destination against the source pattern, plus the word after the end
	task automatic check_copy(input logic [MEM_W-1:0] src, input logic [MEM_W-1:0] dst,
		input logic [MEM_W-1:0] n, input logic fixed_src);
		logic [MEM_W-1:0] k;
		logic [MEM_W-1:0] a;
		for (k = '0; k < n; k++)
		begin
			a = fixed_src ? src : src + k;
			if (mem[dst + k] !== fill_word(a))
				report_mismatch("copied word", mem[dst + k], fill_word(a));
		end
		if (mem[dst + n] !== fill_word(dst + n))
			report_mismatch("word past the end", mem[dst + n], fill_word(dst + n));
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
		begin
			passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic registers_test();
		logic [31:0] q;
		slave_write(dma_pkg::REG_LEN, 32'd5);
		slave_write(dma_pkg::REG_SRC, 32'h00012340);
		slave_write(dma_pkg::REG_DST, 32'h80000abc);
		slave_read(dma_pkg::REG_LEN, q);
		if (q !== 32'd5)
			report_mismatch("length readback", q, 32'd5);
		slave_read(dma_pkg::REG_SRC, q);
		if (q !== 32'h00012340)
			report_mismatch("source readback", q, 32'h00012340);
		slave_read(dma_pkg::REG_DST, q);
		if (q !== 32'h80000abc)
			report_mismatch("destination readback", q, 32'h80000abc);
		slave_read(dma_pkg::REG_CTRL, q);
		if (q[31] !== 1'b0)
			report_mismatch("busy while idle", {31'b0, q[31]}, 32'd0);
		finish_test("registers");
	endtask

	// 37 words in 16-word blocks, a zero block field means full buffer
	task automatic multi_block_test();
		logic [31:0] q;
		int irq_before;
		irq_before = irq_count;
		start_copy(10'h040, 10'h100, 30'd37, 32'h0);
		wait_interrupt();
		repeat (8) @(negedge i_clk);
		if (irq_count != irq_before + 1)
			report_mismatch("interrupt count", irq_count, irq_before + 1);
		check_copy(10'h040, 10'h100, 10'd37, 1'b0);
		slave_read(dma_pkg::REG_LEN, q);
		if (q !== 32'd0)
			report_mismatch("remaining length", q, 32'd0);
		slave_read(dma_pkg::REG_CTRL, q);
		if (q[31] !== 1'b0)
			report_mismatch("busy after copy", {31'b0, q[31]}, 32'd0);
		if (q[9:0] !== 10'd15)
			report_mismatch("block length field", {22'b0, q[9:0]}, 32'd15);
		finish_test("multi_block");
	endtask

	// source increment off, 8-word blocks
	task automatic fixed_source_test();
		start_copy(10'h080, 10'h180, 30'd20, 32'h20000008);
		wait_interrupt();
		repeat (8) @(negedge i_clk);
		check_copy(10'h080, 10'h180, 10'd20, 1'b1);
		finish_test("fixed_source");
	endtask

	task automatic device_trigger_test();
		logic [31:0] q;
		int irq_before;
		int n;
		// every line high except the selected one
		@(posedge i_clk);
		i_dev_ints <= 32'hffffff7f;
		irq_before = irq_count;
		start_copy(10'h0c0, 10'h200, 30'd37, 32'h00009c00);
		for (n = 0; n < 40; n++)
		begin
			@(negedge i_clk);
			if (o_mwb.stb)
				report_mismatch("master strobe with line 7 low", 32'd1, 32'd0);
		end
		slave_read(dma_pkg::REG_CTRL, q);
		if (q[31] !== 1'b1)
			report_mismatch("busy while waiting", {31'b0, q[31]}, 32'd1);
		@(posedge i_clk);
		i_dev_ints <= 32'hffffffff;
		wait_interrupt();
		repeat (8) @(negedge i_clk);
		if (irq_count != irq_before + 1)
			report_mismatch("interrupt count", irq_count, irq_before + 1);
		check_copy(10'h0c0, 10'h200, 10'd37, 1'b0);
		@(posedge i_clk);
		i_dev_ints <= '0;
		finish_test("device_trigger");
	endtask

	// err lands in the second block
	task automatic bus_error_test();
		logic [31:0] q;
		@(posedge i_clk);
		err_word <= 10'h294;
		err_armed <= 1'b1;
		start_copy(10'h280, 10'h300, 30'd30, 32'h0);
		wait_interrupt();
		repeat (8) @(negedge i_clk);
		slave_read(dma_pkg::REG_CTRL, q);
		if (q[31] !== 1'b0)
			report_mismatch("busy after bus error", {31'b0, q[31]}, 32'd0);
		if (q[30] !== 1'b1)
			report_mismatch("error bit after bus error", {31'b0, q[30]}, 32'd1);
		@(posedge i_clk);
		err_armed <= 1'b0;
		// plain idle write clears the flag
		slave_write(dma_pkg::REG_CTRL, 32'h0);
		slave_read(dma_pkg::REG_CTRL, q);
		if (q[30] !== 1'b0)
			report_mismatch("error bit after clear", {31'b0, q[30]}, 32'd0);
		finish_test("bus_error");
	endtask

	task automatic abort_test();
		logic [31:0] q;
		int n;
		start_copy(10'h000, 10'h380, 30'd500, 32'h0);
		n = 0;
		@(negedge i_clk);
		while (!o_mwb.stb && (n < TMO))
		begin
			@(negedge i_clk);
			n++;
		end
		if (!o_mwb.stb)
		begin
			$display("long copy never reached the master bus");
			test_errors++;
		end
		slave_write(dma_pkg::REG_CTRL, dma_pkg::ABORT_WORD);
		// poll until busy drops
		n = 0;
		slave_read(dma_pkg::REG_CTRL, q);
		while (q[31] && (n < 50))
		begin
			slave_read(dma_pkg::REG_CTRL, q);
			n++;
		end
		if (q[31])
		begin
			$display("busy never fell after the abort write");
			test_errors++;
		end
		if (q[30] !== 1'b1)
			report_mismatch("error bit after abort", {31'b0, q[30]}, 32'd1);
		slave_write(dma_pkg::REG_CTRL, 32'h0);
		finish_test("abort");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		repeat (16) @(posedge i_clk);
		i_reset <= 1'b0;
		registers_test();
		multi_block_test();
		fixed_source_test();
		device_trigger_test();
		bus_error_test();
		abort_test();
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
dma_pkg.sv
dma_regs.sv
dma_buffer.sv
dma_engine.sv
dma_top.sv
tb_dma.sv

// File: Makefile
# Verilator build and run for the DMA testbench

VERILATOR ?= verilator
TOP ?= tb_dma
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
